// File: udp_echo_pkg.sv
// UDP echo package with field widths, header and beat types, and reply constants
package udp_echo_pkg;

    localparam int IP_ADDR_W = 32;
    localparam int PORT_W    = 16;
    localparam int LEN_W     = 16;
    localparam int TTL_W     = 8;
    localparam int BYTE_W    = 8;

    typedef logic [IP_ADDR_W-1:0] ip_addr_t;
    typedef logic [PORT_W-1:0]    udp_port_t;
    typedef logic [LEN_W-1:0]     udp_len_t;
    typedef logic [TTL_W-1:0]     ttl_t;
    typedef logic [BYTE_W-1:0]    byte_t;

    // Reply header as it sits in the header queue
    typedef struct packed {
        ip_addr_t  src_ip;
        ip_addr_t  dest_ip;
        udp_port_t src_port;
        udp_port_t dest_port;
        udp_len_t  length;
    } udp_hdr_t;

    // One payload byte with its framing flags
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } beat_t;

    // Fixed time-to-live of every echoed datagram
    localparam ttl_t REPLY_TTL = 8'd64;

    // Configuration register select
    typedef logic cfg_addr_t;

    localparam cfg_addr_t CFG_ADDR_PORT = 1'b0;
    localparam cfg_addr_t CFG_ADDR_IP   = 1'b1;

endpackage

// File: udp_stream_if.sv
// Byte-wide payload stream interface with source and sink modports
`timescale 1ns/1ns

interface udp_stream_if;

    udp_echo_pkg::byte_t data;
    logic                valid;
    logic                ready;
    logic                last;
    logic                user;

    // Producer side
    modport source (
        output data,
        output valid,
        output last,
        output user,
        input  ready
    );

    // Consumer side
    modport sink (
        input  data,
        input  valid,
        input  last,
        input  user,
        output ready
    );

endinterface

// File: echo_config.sv
// Echo port and local IP configuration registers with write strobe
`timescale 1ns/1ns

module echo_config #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT_INIT = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP_INIT  = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cfg_we,
    input  udp_echo_pkg::cfg_addr_t  cfg_addr,
    input  logic [31:0]              cfg_wdata,
    output udp_echo_pkg::udp_port_t  echo_port,
    output udp_echo_pkg::ip_addr_t   local_ip
);

    udp_echo_pkg::udp_port_t echo_port_q;
    udp_echo_pkg::ip_addr_t  local_ip_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            echo_port_q <= ECHO_PORT_INIT;
            local_ip_q  <= LOCAL_IP_INIT;
        end else if (cfg_we) begin
            case (cfg_addr)
                udp_echo_pkg::CFG_ADDR_PORT: begin
                    // Port takes the low half of the write data
                    echo_port_q <= cfg_wdata[udp_echo_pkg::PORT_W-1:0];
                end
                udp_echo_pkg::CFG_ADDR_IP: begin
                    local_ip_q <= cfg_wdata[udp_echo_pkg::IP_ADDR_W-1:0];
                end
            endcase
        end
    end

    assign echo_port = echo_port_q;
    assign local_ip  = local_ip_q;

endmodule

// File: udp_port_filter.sv
// Per-datagram port match, reply header build and payload gating or draining
`timescale 1ns/1ns

module udp_port_filter (
    input  logic                     clk,
    input  logic                     rst,

    input  udp_echo_pkg::udp_port_t  echo_port,
    input  udp_echo_pkg::ip_addr_t   local_ip,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   rx_src_ip,
    input  udp_echo_pkg::udp_port_t  rx_src_port,
    input  udp_echo_pkg::udp_port_t  rx_dest_port,
    input  udp_echo_pkg::udp_len_t   rx_length,

    input  udp_echo_pkg::byte_t      rx_payload_data,
    input  logic                     rx_payload_valid,
    input  logic                     rx_payload_last,
    input  logic                     rx_payload_user,
    output logic                     rx_payload_ready,

    output udp_echo_pkg::udp_hdr_t   reply_hdr,
    output logic                     reply_valid,
    input  logic                     reply_ready,

    udp_stream_if.source             keep
);

    // Payload of an accepted header not yet finished
    logic open_q;
    // Decision for the open datagram
    logic match_q;

    logic hdr_match;
    logic hdr_fire;
    logic pay_fire;

    assign hdr_match = (rx_dest_port == echo_port);

    // A matched header needs room in the reply queue
    assign rx_hdr_ready = !open_q && (!hdr_match || reply_ready);
    assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;

    assign reply_valid = rx_hdr_valid && !open_q && hdr_match;

    // Ports swapped, reply goes back to the sender
    assign reply_hdr = '{
        src_ip:    local_ip,
        dest_ip:   rx_src_ip,
        src_port:  rx_dest_port,
        dest_port: rx_src_port,
        length:    rx_length
    };

    // Kept payload follows queue back-pressure, dropped payload drains freely
    assign keep.data  = rx_payload_data;
    assign keep.last  = rx_payload_last;
    assign keep.user  = rx_payload_user;
    assign keep.valid = rx_payload_valid && open_q && match_q;

    assign rx_payload_ready = open_q && (match_q ? keep.ready : 1'b1);
    assign pay_fire         = rx_payload_valid && rx_payload_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            open_q  <= 1'b0;
            match_q <= 1'b0;
        end else begin
            if (hdr_fire) begin
                open_q  <= 1'b1;
                match_q <= hdr_match;
            end else if (pay_fire && rx_payload_last) begin
                open_q  <= 1'b0;
                match_q <= 1'b0;
            end
        end
    end

endmodule

// File: stream_fifo.sv
// First-word-fall-through stream FIFO with a type parameter for its item
`timescale 1ns/1ns

module stream_fifo #(
    parameter type item_t     = logic,
    parameter int  ADDR_WIDTH = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  item_t in_item,
    input  logic  in_valid,
    output logic  in_ready,

    output item_t out_item,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    item_t mem [0:DEPTH-1];

    // Extra top bit separates full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;

    assign wr_en = in_valid && in_ready;
    assign rd_en = out_valid && out_ready;

    // Head entry shown directly, stays put until read
    assign out_item = mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: udp_echo_core.sv
// UDP echo core top level with filter, header and payload FIFOs, config and LED capture
`timescale 1ns/1ns

module udp_echo_core #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT_INIT     = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP_INIT      = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter int                      PAYLOAD_ADDR_WIDTH = 12,
    parameter int                      HDR_ADDR_WIDTH     = 2
) (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     rx_hdr_valid,
    output logic                     rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t   rx_src_ip,
    input  udp_echo_pkg::udp_port_t  rx_src_port,
    input  udp_echo_pkg::udp_port_t  rx_dest_port,
    input  udp_echo_pkg::udp_len_t   rx_length,

    input  udp_echo_pkg::byte_t      rx_payload_data,
    input  logic                     rx_payload_valid,
    input  logic                     rx_payload_last,
    input  logic                     rx_payload_user,
    output logic                     rx_payload_ready,

    output logic                     tx_hdr_valid,
    input  logic                     tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t   tx_src_ip,
    output udp_echo_pkg::ip_addr_t   tx_dest_ip,
    output udp_echo_pkg::udp_port_t  tx_src_port,
    output udp_echo_pkg::udp_port_t  tx_dest_port,
    output udp_echo_pkg::udp_len_t   tx_length,
    output udp_echo_pkg::ttl_t       tx_ttl,

    output udp_echo_pkg::byte_t      tx_payload_data,
    output logic                     tx_payload_valid,
    output logic                     tx_payload_last,
    output logic                     tx_payload_user,
    input  logic                     tx_payload_ready,

    input  logic                     cfg_we,
    input  udp_echo_pkg::cfg_addr_t  cfg_addr,
    input  logic [31:0]              cfg_wdata,

    output udp_echo_pkg::byte_t      led
);

    udp_echo_pkg::udp_port_t echo_port;
    udp_echo_pkg::ip_addr_t  local_ip;

    udp_echo_pkg::udp_hdr_t  reply_hdr;
    logic                    reply_valid;
    logic                    reply_ready;
    udp_echo_pkg::udp_hdr_t  tx_hdr;

    udp_echo_pkg::beat_t     pay_in;
    udp_echo_pkg::beat_t     pay_out;

    udp_stream_if rx_keep ();
    udp_stream_if tx_pay ();

    echo_config #(
        .ECHO_PORT_INIT (ECHO_PORT_INIT),
        .LOCAL_IP_INIT  (LOCAL_IP_INIT)
    ) u_config (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .echo_port (echo_port),
        .local_ip  (local_ip)
    );

    udp_port_filter u_filter (
        .clk              (clk),
        .rst              (rst),
        .echo_port        (echo_port),
        .local_ip         (local_ip),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_src_ip        (rx_src_ip),
        .rx_src_port      (rx_src_port),
        .rx_dest_port     (rx_dest_port),
        .rx_length        (rx_length),
        .rx_payload_data  (rx_payload_data),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_last  (rx_payload_last),
        .rx_payload_user  (rx_payload_user),
        .rx_payload_ready (rx_payload_ready),
        .reply_hdr        (reply_hdr),
        .reply_valid      (reply_valid),
        .reply_ready      (reply_ready),
        .keep             (rx_keep)
    );

    stream_fifo #(
        .item_t     (udp_echo_pkg::udp_hdr_t),
        .ADDR_WIDTH (HDR_ADDR_WIDTH)
    ) u_hdr_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (reply_hdr),
        .in_valid  (reply_valid),
        .in_ready  (reply_ready),
        .out_item  (tx_hdr),
        .out_valid (tx_hdr_valid),
        .out_ready (tx_hdr_ready)
    );

    // Stream signals packed into one FIFO word
    assign pay_in = '{data: rx_keep.data, last: rx_keep.last, user: rx_keep.user};

    stream_fifo #(
        .item_t     (udp_echo_pkg::beat_t),
        .ADDR_WIDTH (PAYLOAD_ADDR_WIDTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_item   (pay_in),
        .in_valid  (rx_keep.valid),
        .in_ready  (rx_keep.ready),
        .out_item  (pay_out),
        .out_valid (tx_pay.valid),
        .out_ready (tx_pay.ready)
    );

    assign tx_pay.data  = pay_out.data;
    assign tx_pay.last  = pay_out.last;
    assign tx_pay.user  = pay_out.user;
    assign tx_pay.ready = tx_payload_ready;

    assign tx_payload_data  = tx_pay.data;
    assign tx_payload_valid = tx_pay.valid;
    assign tx_payload_last  = tx_pay.last;
    assign tx_payload_user  = tx_pay.user;

    assign tx_src_ip    = tx_hdr.src_ip;
    assign tx_dest_ip   = tx_hdr.dest_ip;
    assign tx_src_port  = tx_hdr.src_port;
    assign tx_dest_port = tx_hdr.dest_port;
    assign tx_length    = tx_hdr.length;
    assign tx_ttl       = udp_echo_pkg::REPLY_TTL;

    // LED capture of the first byte of each outgoing datagram
    logic in_dgram_q;
    logic tx_fire;

    assign tx_fire = tx_pay.valid && tx_pay.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_dgram_q <= 1'b0;
            led        <= '0;
        end else begin
            if (tx_pay.valid && !in_dgram_q) begin
                led <= tx_pay.data;
            end
            if (tx_fire) begin
                // Cleared again by the last beat
                in_dgram_q <= !tx_pay.last;
            end
        end
    end

endmodule

// File: udp_echo_sva.sv
// Concurrent assertions on the echo core transmit handshakes and reset state, with bind
`timescale 1ns/1ns

module udp_echo_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    rx_hdr_ready,
    input logic                    tx_hdr_valid,
    input logic                    tx_hdr_ready,
    input udp_echo_pkg::ip_addr_t  tx_src_ip,
    input udp_echo_pkg::ip_addr_t  tx_dest_ip,
    input udp_echo_pkg::udp_port_t tx_src_port,
    input udp_echo_pkg::udp_port_t tx_dest_port,
    input udp_echo_pkg::udp_len_t  tx_length,
    input udp_echo_pkg::byte_t     tx_payload_data,
    input logic                    tx_payload_valid,
    input logic                    tx_payload_last,
    input logic                    tx_payload_user,
    input logic                    tx_payload_ready
);

    hdr_valid_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid)
        else $error("tx_hdr_valid dropped before ready");

    hdr_data_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=>
            $stable({tx_src_ip, tx_dest_ip, tx_src_port, tx_dest_port, tx_length}))
        else $error("tx header fields changed while stalled");

    pay_valid_hold: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=> tx_payload_valid)
        else $error("tx_payload_valid dropped before ready");

    pay_data_hold: assert property (@(posedge clk) disable iff (rst)
        tx_payload_valid && !tx_payload_ready |=>
            $stable({tx_payload_data, tx_payload_last, tx_payload_user}))
        else $error("tx payload beat changed while stalled");

    // Receive side open for a header straight out of reset
    hdr_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> rx_hdr_ready)
        else $error("rx_hdr_ready low after reset");

endmodule

bind udp_echo_core udp_echo_sva u_sva (
    .clk              (clk),
    .rst              (rst),
    .rx_hdr_ready     (rx_hdr_ready),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_src_ip        (tx_src_ip),
    .tx_dest_ip       (tx_dest_ip),
    .tx_src_port      (tx_src_port),
    .tx_dest_port     (tx_dest_port),
    .tx_length        (tx_length),
    .tx_payload_data  (tx_payload_data),
    .tx_payload_valid (tx_payload_valid),
    .tx_payload_last  (tx_payload_last),
    .tx_payload_user  (tx_payload_user),
    .tx_payload_ready (tx_payload_ready)
);

// File: tb_udp_echo.sv
// Testbench for the UDP echo core with stimulus, reference model, compare process and watchdog
`timescale 1ns/1ns

module tb_udp_echo;

    localparam udp_echo_pkg::udp_port_t ECHO_PORT_INIT = 16'd1234;
    localparam udp_echo_pkg::ip_addr_t  LOCAL_IP_INIT  = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam logic [7:0]              TTL_EXP        = 8'd64;
    localparam int N_DGRAMS       = 48;
    localparam int MAX_LEN        = 16;
    localparam int TIMEOUT_CYCLES = N_DGRAMS * MAX_LEN * 4 + 1000;

    logic                    clk;
    logic                    rst;
    logic                    rx_hdr_valid;
    logic                    rx_hdr_ready;
    udp_echo_pkg::ip_addr_t  rx_src_ip;
    udp_echo_pkg::udp_port_t rx_src_port;
    udp_echo_pkg::udp_port_t rx_dest_port;
    udp_echo_pkg::udp_len_t  rx_length;
    udp_echo_pkg::byte_t     rx_payload_data;
    logic                    rx_payload_valid;
    logic                    rx_payload_last;
    logic                    rx_payload_user;
    logic                    rx_payload_ready;
    logic                    tx_hdr_valid;
    logic                    tx_hdr_ready;
    udp_echo_pkg::ip_addr_t  tx_src_ip;
    udp_echo_pkg::ip_addr_t  tx_dest_ip;
    udp_echo_pkg::udp_port_t tx_src_port;
    udp_echo_pkg::udp_port_t tx_dest_port;
    udp_echo_pkg::udp_len_t  tx_length;
    udp_echo_pkg::ttl_t      tx_ttl;
    udp_echo_pkg::byte_t     tx_payload_data;
    logic                    tx_payload_valid;
    logic                    tx_payload_last;
    logic                    tx_payload_user;
    logic                    tx_payload_ready;
    logic                    cfg_we;
    udp_echo_pkg::cfg_addr_t cfg_addr;
    logic [31:0]             cfg_wdata;
    udp_echo_pkg::byte_t     led;

    // Model state and expected output queues
    udp_echo_pkg::udp_port_t model_port;
    udp_echo_pkg::ip_addr_t  model_ip;
    udp_echo_pkg::udp_hdr_t  exp_hdr_q[$];
    udp_echo_pkg::beat_t     exp_beat_q[$];

    logic [31:0] rng_stim;
    logic [31:0] rng_ready;
    logic        rand_ready;
    logic        tx_in_dgram;
    logic        led_pending;
    logic [7:0]  led_expected;
    int          hdr_errors;
    int          pay_errors;
    int          led_errors;
    int          other_errors;

    udp_echo_core #(
        .ECHO_PORT_INIT     (ECHO_PORT_INIT),
        .LOCAL_IP_INIT      (LOCAL_IP_INIT),
        .PAYLOAD_ADDR_WIDTH (12),
        .HDR_ADDR_WIDTH     (2)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Echo rules: keep on port match, swap ports, reply to sender from the local IP
    function automatic logic echo_model(input udp_echo_pkg::ip_addr_t src_ip,
                                        input udp_echo_pkg::udp_port_t src_port,
                                        input udp_echo_pkg::udp_port_t dest_port,
                                        input udp_echo_pkg::udp_len_t length,
                                        output udp_echo_pkg::udp_hdr_t reply);
        reply.src_ip    = model_ip;
        reply.dest_ip   = src_ip;
        reply.src_port  = dest_port;
        reply.dest_port = src_port;
        reply.length    = length;
        return (dest_port == model_port);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, inout int count);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
            count++;
        end
    endtask

    task automatic send_datagram(input udp_echo_pkg::ip_addr_t src_ip,
                                 input udp_echo_pkg::udp_port_t src_port,
                                 input udp_echo_pkg::udp_port_t dest_port,
                                 input int nbytes);
        udp_echo_pkg::udp_hdr_t reply;
        udp_echo_pkg::beat_t    beat;
        logic                   kept;
        int                     i;
        kept = echo_model(src_ip, src_port, dest_port, udp_echo_pkg::udp_len_t'(nbytes + 8),
                          reply);
        if (kept) begin
            exp_hdr_q.push_back(reply);
        end
        @(posedge clk);
        rx_hdr_valid <= 1'b1;
        rx_src_ip    <= src_ip;
        rx_src_port  <= src_port;
        rx_dest_port <= dest_port;
        rx_length    <= udp_echo_pkg::udp_len_t'(nbytes + 8);
        do @(posedge clk); while (!rx_hdr_ready);
        rx_hdr_valid <= 1'b0;
        for (i = 0; i < nbytes; i++) begin
            rng_stim  = next_random(rng_stim);
            beat.data = rng_stim[7:0];
            beat.last = (i == nbytes - 1);
            beat.user = rng_stim[8];
            if (kept) begin
                exp_beat_q.push_back(beat);
            end
            rx_payload_valid <= 1'b1;
            rx_payload_data  <= beat.data;
            rx_payload_last  <= beat.last;
            rx_payload_user  <= beat.user;
            @(posedge clk);
            while (!rx_payload_ready) begin
                if (!kept) begin
                    $display("Dropped datagram payload was stalled at %0t ns", $time);
                    other_errors++;
                end
                @(posedge clk);
            end
        end
        rx_payload_valid <= 1'b0;
    endtask

    // Matched, old-port and random-port datagrams in random order
    task automatic send_mix(input int count, input udp_echo_pkg::udp_port_t other_port);
        udp_echo_pkg::udp_port_t dest;
        udp_echo_pkg::ip_addr_t  ip;
        int                      n;
        for (n = 0; n < count; n++) begin
            rng_stim = next_random(rng_stim);
            if (rng_stim[0]) begin
                dest = model_port;
            end else if (rng_stim[1]) begin
                dest = other_port;
            end else begin
                dest = rng_stim[31:16];
                if (dest == model_port) begin
                    dest = dest ^ 16'h8000;
                end
            end
            rng_stim = next_random(rng_stim);
            ip       = rng_stim;
            rng_stim = next_random(rng_stim);
            send_datagram(ip, rng_stim[31:16], dest, 1 + rng_stim[3:0]);
        end
    endtask

    task automatic write_config(input udp_echo_pkg::cfg_addr_t addr, input logic [31:0] wdata);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= wdata;
        @(posedge clk);
        cfg_we <= 1'b0;
        if (addr == udp_echo_pkg::CFG_ADDR_PORT) begin
            model_port = wdata[15:0];
        end else begin
            model_ip = wdata;
        end
    endtask

    // Random back-pressure on both transmit outputs
    always @(posedge clk) begin
        if (rand_ready) begin
            rng_ready = next_random(rng_ready);
            tx_hdr_ready     <= (rng_ready[1:0] != 2'b00);
            tx_payload_ready <= (rng_ready[3:2] != 2'b00);
        end else begin
            tx_hdr_ready     <= 1'b1;
            tx_payload_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin : compare_proc
        udp_echo_pkg::udp_hdr_t exp_hdr;
        udp_echo_pkg::beat_t    exp_beat;
        if (!rst) begin
            if (led_pending) begin
                check_value("led", led_expected, led, led_errors);
                led_pending = 1'b0;
            end
            // First beat of a datagram on the output
            if (tx_payload_valid && !tx_in_dgram && exp_beat_q.size() != 0) begin
                led_expected = exp_beat_q[0].data;
                led_pending  = 1'b1;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    $display("Reply header sent at %0t ns with no echo pending", $time);
                    other_errors++;
                end else begin
                    exp_hdr = exp_hdr_q.pop_front();
                    check_value("tx_src_ip", exp_hdr.src_ip, tx_src_ip, hdr_errors);
                    check_value("tx_dest_ip", exp_hdr.dest_ip, tx_dest_ip, hdr_errors);
                    check_value("tx_src_port", exp_hdr.src_port, tx_src_port, hdr_errors);
                    check_value("tx_dest_port", exp_hdr.dest_port, tx_dest_port, hdr_errors);
                    check_value("tx_length", exp_hdr.length, tx_length, hdr_errors);
                    check_value("tx_ttl", TTL_EXP, tx_ttl, hdr_errors);
                end
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_beat_q.size() == 0) begin
                    $display("Payload beat sent at %0t ns with no echo pending", $time);
                    other_errors++;
                end else begin
                    exp_beat = exp_beat_q.pop_front();
                    check_value("tx_payload_data", exp_beat.data, tx_payload_data, pay_errors);
                    check_value("tx_payload_last", exp_beat.last, tx_payload_last, pay_errors);
                    check_value("tx_payload_user", exp_beat.user, tx_payload_user, pay_errors);
                end
                tx_in_dgram = !tx_payload_last;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the echo core did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst              = 1'b1;
        rx_hdr_valid     = 1'b0;
        rx_src_ip        = '0;
        rx_src_port      = '0;
        rx_dest_port     = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        tx_hdr_ready     = 1'b1;
        tx_payload_ready = 1'b1;
        cfg_we           = 1'b0;
        cfg_addr         = udp_echo_pkg::CFG_ADDR_PORT;
        cfg_wdata        = '0;
        model_port       = ECHO_PORT_INIT;
        model_ip         = LOCAL_IP_INIT;
        rng_stim         = 32'd58896;
        rng_ready        = 32'd58896 ^ 32'h9e3779b9;
        rand_ready       = 1'b0;
        tx_in_dgram      = 1'b0;
        led_pending      = 1'b0;
        led_expected     = '0;
        hdr_errors       = 0;
        pay_errors       = 0;
        led_errors       = 0;
        other_errors     = 0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("tx_hdr_valid", 0, tx_hdr_valid, other_errors);
        check_value("tx_payload_valid", 0, tx_payload_valid, other_errors);
        check_value("rx_payload_ready", 0, rx_payload_ready, other_errors);
        check_value("rx_hdr_ready", 1, rx_hdr_ready, other_errors);
        check_value("led", 0, led, led_errors);

        // Directed echo, then two datagrams for other ports
        send_datagram({8'd10, 8'd0, 8'd0, 8'd5}, 16'd5555, 16'd1234, 8);
        send_datagram({8'd10, 8'd0, 8'd0, 8'd6}, 16'd4000, 16'd80, 12);
        send_datagram({8'd10, 8'd0, 8'd0, 8'd7}, 16'd4001, 16'd1235, 5);

        rand_ready <= 1'b1;
        send_mix(30, 16'd53);

        // New echo port and local IP, the old port is dropped afterwards
        write_config(udp_echo_pkg::CFG_ADDR_PORT, 32'h0000_10e1);
        write_config(udp_echo_pkg::CFG_ADDR_IP, {8'd10, 8'd1, 8'd2, 8'd3});
        send_datagram({8'd172, 8'd16, 8'd0, 8'd9}, 16'd7000, 16'd1234, 6);
        send_datagram({8'd172, 8'd16, 8'd0, 8'd9}, 16'd7001, 16'd4321, 9);
        send_mix(8, 16'd1234);

        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check_value("tx_hdr_valid", 0, tx_hdr_valid, other_errors);
        check_value("tx_payload_valid", 0, tx_payload_valid, other_errors);

        $display("Errors: header %0d, payload %0d, led %0d, other %0d",
                 hdr_errors, pay_errors, led_errors, other_errors);
        if (hdr_errors + pay_errors + led_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
udp_echo_pkg.sv
udp_stream_if.sv
echo_config.sv
udp_port_filter.sv
stream_fifo.sv
udp_echo_core.sv
udp_echo_sva.sv
tb_udp_echo.sv

// File: Bender.yml
package:
  name: udp_echo

sources:
  - udp_echo_pkg.sv
  - udp_stream_if.sv
  - echo_config.sv
  - udp_port_filter.sv
  - stream_fifo.sv
  - udp_echo_core.sv
  - target: test
    files:
      - udp_echo_sva.sv
      - tb_udp_echo.sv
